// File: vlog.f
+incdir+dv
logic/csa_pkg.sv
logic/ring_if.sv
logic/ring_entry.sv
logic/keystream_mixer.sv
logic/ring_delay.sv
logic/pass_check.sv
logic/csa_search.sv
dv/csa_search_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
	-f vlog.f \
	--top-module csa_search_tb \
	-Mdir obj_dir

./obj_dir/Vcsa_search_tb

// File: dv/csa_search_tests.svh
// test table, one row per test
// columns are name, jobs, largest P, mask from a known v(n) and random out_full
localparam int NUM_TESTS = 4;
localparam int MAX_JOBS = 32;
localparam int MAX_P = 5;

string test_name [NUM_TESTS] = '{"mask_off", "mask_match", "ring_overfill", "out_full"};
localparam int TEST_JOBS [NUM_TESTS] = '{4, 3, 30, 12};
localparam int TEST_PMAX [NUM_TESTS] = '{3, 5, 5, 5};
localparam bit TEST_MASK [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1};
localparam bit TEST_FULL [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
	logic [63:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = {r[62:0], lfsr_state[0]};
	end
	return r;
endfunction

// one pass is CIPHER_STAGES rounds of xor then rotate left by a byte
function automatic csa_pkg::word_t mix_pass(input csa_pkg::word_t w);
	csa_pkg::word_t x;
	x = w;
	for (int r = 0; r < CIPHER_STAGES; r++) begin
		x = x ^ csa_pkg::MIX_CONST;
		x = {x[55:0], x[63:56]};
	end
	return x;
endfunction

// v(n) from the seed
function automatic csa_pkg::word_t word_after(input csa_pkg::word_t seed, input int n);
	csa_pkg::word_t w;
	w = seed;
	for (int i = 0; i < n; i++)
		w = mix_pass(w);
	return w;
endfunction

// File: dv/csa_search_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csa_search_tb;

	localparam int RING_DEPTH = 22;
	localparam int CIPHER_STAGES = 4;
	localparam int FIFO_LATENCY = 3;

	logic clk;
	logic rst_n;
	logic fifo_ready_i;
	logic fifo_ren_o;
	csa_pkg::tag_t job_tag_i;
	csa_pkg::word_t job_seed_i;
	csa_pkg::count_t job_total_i;
	csa_pkg::count_t job_start_i;
	logic mask_enable_i;
	csa_pkg::word_t mask_i;
	csa_pkg::word_t value_i;
	logic out_full_i;
	logic result_valid_o;
	csa_pkg::word_t result_o;
	csa_pkg::tag_t result_tag_o;
	csa_pkg::word_t result_seed_o;
	csa_pkg::count_t result_total_o;
	csa_pkg::count_t result_start_o;

	logic [31:0] lfsr_state;

	`include "csa_search_tests.svh"

	string cur_name;
	int jobs_n;
	int issued;
	int cap_idx;
	int got_total;
	int exp_total;
	bit test_active;
	bit full_mode;
	bit full_seen;
	logic [FIFO_LATENCY-2:0] pend; // read pulses waiting for capture

	csa_pkg::tag_t job_tag [MAX_JOBS];
	csa_pkg::word_t job_seed [MAX_JOBS];
	csa_pkg::count_t job_total [MAX_JOBS];
	csa_pkg::count_t job_start [MAX_JOBS];
	csa_pkg::word_t exp_word [MAX_JOBS][MAX_P];
	int exp_cnt [MAX_JOBS];
	int got_cnt [MAX_JOBS];

	csa_search #(
		.RING_DEPTH(RING_DEPTH),
		.CIPHER_STAGES(CIPHER_STAGES),
		.FIFO_LATENCY(FIFO_LATENCY)
	) dut (
		.clk(clk), .rst_n(rst_n),
		.fifo_ready_i(fifo_ready_i), .fifo_ren_o(fifo_ren_o),
		.job_tag_i(job_tag_i), .job_seed_i(job_seed_i),
		.job_total_i(job_total_i), .job_start_i(job_start_i),
		.mask_enable_i(mask_enable_i), .mask_i(mask_i), .value_i(value_i),
		.out_full_i(out_full_i),
		.result_valid_o(result_valid_o), .result_o(result_o),
		.result_tag_o(result_tag_o), .result_seed_o(result_seed_o),
		.result_total_o(result_total_o), .result_start_o(result_start_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_failed();
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_with(input string msg);
		$display("%s in test %s", msg, cur_name);
		stop_failed();
	endtask

	task automatic compare_word(input string what, input csa_pkg::word_t exp,
			input csa_pkg::word_t act);
		if (exp !== act) begin
			$display("ERROR %s: %s expected %h, actual %h", cur_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_tag(input string what, input csa_pkg::tag_t exp,
			input csa_pkg::tag_t act);
		if (exp !== act) begin
			$display("ERROR %s: %s expected %h, actual %h", cur_name, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic compare_count(input string what, input csa_pkg::count_t exp,
			input csa_pkg::count_t act);
		if (exp !== act) begin
			$display("ERROR %s: %s expected %0d, actual %0d", cur_name, what, exp, act);
			stop_failed();
		end
	endtask

	// FIFO source model and out_full pattern
	always @(posedge clk) begin
		logic [63:0] r;
		if (rst_n) begin
			if (fifo_ren_o) begin
				if (issued >= jobs_n)
					fail_with("FIFO read issued with no job left");
				issued = issued + 1;
			end
			if (pend[FIFO_LATENCY-2]) begin
				job_tag_i <= job_tag[cap_idx];
				job_seed_i <= job_seed[cap_idx];
				job_total_i <= job_total[cap_idx];
				job_start_i <= job_start[cap_idx];
				cap_idx = cap_idx + 1;
			end
			pend <= (pend << 1) | (FIFO_LATENCY-1)'(fifo_ren_o);
			fifo_ready_i <= (issued < jobs_n);
			r = full_mode ? rand_bits(2) : 64'd0;
			out_full_i <= (r[1:0] == 2'b11);
		end
	end

	// output monitor
	always @(posedge clk) begin
		int idx;
		if (rst_n && result_valid_o) begin
			idx = {24'd0, result_tag_o[7:0]};
			if (!test_active || idx >= jobs_n)
				fail_with("result with an unknown tag");
			if (full_seen)
				fail_with("result emitted right after a full end of pass");
			if (got_cnt[idx] >= exp_cnt[idx])
				fail_with("extra result for a job");
			compare_tag("tag", job_tag[idx], result_tag_o);
			compare_word("result", exp_word[idx][got_cnt[idx]], result_o);
			compare_word("seed echo", job_seed[idx], result_seed_o);
			compare_count("total echo", job_total[idx], result_total_o);
			compare_count("start echo", job_start[idx], result_start_o);
			got_cnt[idx] = got_cnt[idx] + 1;
			got_total = got_total + 1;
		end
		full_seen = rst_n && out_full_i;
	end

	// watchdog sized from the table
	initial begin
		int budget;
		budget = 200 + 20 + NUM_TESTS * 2 * RING_DEPTH;
		for (int t = 0; t < NUM_TESTS; t++)
			budget += TEST_JOBS[t] * (TEST_PMAX[t] + 4) * RING_DEPTH;
		repeat (budget) @(posedge clk);
		$display("timeout: results still missing in test %s", cur_name);
		stop_failed();
	end

	initial begin
		logic [63:0] r;
		int p;
		csa_pkg::word_t w;
		csa_pkg::word_t m;
		csa_pkg::word_t val;
		rst_n = 1'b0;
		fifo_ready_i = 1'b0;
		job_tag_i = '0;
		job_seed_i = '0;
		job_total_i = '0;
		job_start_i = '0;
		mask_enable_i = 1'b0;
		mask_i = '0;
		value_i = '0;
		out_full_i = 1'b0;
		lfsr_state = 32'h6499_5470;
		cur_name = "reset";
		jobs_n = 0;
		issued = 0;
		cap_idx = 0;
		got_total = 0;
		exp_total = 0;
		test_active = 1'b0;
		full_mode = 1'b0;
		full_seen = 1'b0;
		pend = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (10) begin
			@(posedge clk);
			if (fifo_ren_o || result_valid_o)
				fail_with("output active after reset with the FIFO not ready");
		end

		for (int t = 0; t < NUM_TESTS; t++) begin
			@(posedge clk);
			cur_name = test_name[t];
			for (int j = 0; j < TEST_JOBS[t]; j++) begin
				job_tag[j] = (t << 8) | j;
				job_seed[j] = rand_bits(64);
				r = rand_bits(8);
				p = 1 + (r[7:0] % TEST_PMAX[t]);
				if (j == 0 && TEST_MASK[t])
					p = TEST_PMAX[t]; // first job passes the matched v(2)
				r = rand_bits(8);
				job_start[j] = {24'd0, r[7:0]};
				job_total[j] = job_start[j] + p;
			end
			m = rand_bits(64) | 64'hFF;
			val = word_after(job_seed[0], 2);
			for (int j = 0; j < TEST_JOBS[t]; j++) begin
				exp_cnt[j] = 0;
				got_cnt[j] = 0;
				w = job_seed[j];
				p = job_total[j] - job_start[j];
				for (int n = 1; n <= p; n++) begin
					w = mix_pass(w);
					if (n == p || (TEST_MASK[t] && ((w & m) == (val & m)))) begin
						exp_word[j][exp_cnt[j]] = w;
						exp_cnt[j] = exp_cnt[j] + 1;
					end
				end
			end
			exp_total = 0;
			for (int j = 0; j < TEST_JOBS[t]; j++)
				exp_total += exp_cnt[j];
			mask_enable_i <= TEST_MASK[t];
			mask_i <= m;
			value_i <= val;
			got_total = 0;
			issued = 0;
			cap_idx = 0;
			test_active = 1'b1;
			full_mode = TEST_FULL[t];
			jobs_n = TEST_JOBS[t];
			while (got_total < exp_total)
				@(posedge clk);
			full_mode = 1'b0;
			repeat (2 * RING_DEPTH) @(posedge clk); // any late extra result shows here
			if (issued != jobs_n)
				fail_with("FIFO read count differs from the job count");
			test_active = 1'b0;
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/csa_search.sv
`timescale 1ns/1ps
`default_nettype none

module csa_search #(
	parameter int RING_DEPTH = 22,
	parameter int CIPHER_STAGES = 4,
	parameter int FIFO_LATENCY = 3
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic fifo_ready_i,
	output logic fifo_ren_o,
	input wire csa_pkg::tag_t job_tag_i,
	input wire csa_pkg::word_t job_seed_i,
	input wire csa_pkg::count_t job_total_i,
	input wire csa_pkg::count_t job_start_i,

	input wire logic mask_enable_i,
	input wire csa_pkg::word_t mask_i,
	input wire csa_pkg::word_t value_i,
	input wire logic out_full_i,

	output logic result_valid_o,
	output csa_pkg::word_t result_o,
	output csa_pkg::tag_t result_tag_o,
	output csa_pkg::word_t result_seed_o,
	output csa_pkg::count_t result_total_o,
	output csa_pkg::count_t result_start_o
);

	// one cycle each for entry and check and the rest pads the ring
	localparam int DELAY_STAGES = RING_DEPTH - CIPHER_STAGES - 2;

	ring_if entry_to_mix ();
	ring_if mix_to_delay ();
	ring_if delay_to_check ();
	ring_if check_to_entry ();

	csa_pkg::word_t mix_key;
	csa_pkg::word_t dly_key;
	logic tap_busy;

	ring_entry #(
		.FIFO_LATENCY(FIFO_LATENCY)
	) u_entry (
		.clk(clk),
		.rst_n(rst_n),
		.fifo_ready_i(fifo_ready_i),
		.tap_busy_i(tap_busy),
		.fifo_ren_o(fifo_ren_o),
		.job_tag_i(job_tag_i),
		.job_seed_i(job_seed_i),
		.job_total_i(job_total_i),
		.job_start_i(job_start_i),
		.loop_in(check_to_entry),
		.ring_out(entry_to_mix)
	);

	keystream_mixer #(
		.CIPHER_STAGES(CIPHER_STAGES)
	) u_mixer (
		.clk(clk),
		.rst_n(rst_n),
		.mix_in(entry_to_mix),
		.mix_out(mix_to_delay),
		.key_o(mix_key)
	);

	ring_delay #(
		.DELAY_STAGES(DELAY_STAGES),
		.FIFO_LATENCY(FIFO_LATENCY)
	) u_delay (
		.clk(clk),
		.rst_n(rst_n),
		.dly_in(mix_to_delay),
		.key_i(mix_key),
		.dly_out(delay_to_check),
		.key_o(dly_key),
		.tap_busy_o(tap_busy)
	);

	pass_check u_check (
		.clk(clk),
		.rst_n(rst_n),
		.chk_in(delay_to_check),
		.key_i(dly_key),
		.mask_enable_i(mask_enable_i),
		.mask_i(mask_i),
		.value_i(value_i),
		.out_full_i(out_full_i),
		.loop_out(check_to_entry),
		.result_valid_o(result_valid_o),
		.result_o(result_o),
		.result_tag_o(result_tag_o),
		.result_seed_o(result_seed_o),
		.result_total_o(result_total_o),
		.result_start_o(result_start_o)
	);

endmodule

`default_nettype wire

// File: logic/pass_check.sv
`timescale 1ns/1ps
`default_nettype none

module pass_check (
	input wire logic clk,
	input wire logic rst_n,

	ring_if.snk chk_in,
	input wire csa_pkg::word_t key_i,

	input wire logic mask_enable_i,
	input wire csa_pkg::word_t mask_i,
	input wire csa_pkg::word_t value_i,
	input wire logic out_full_i,

	ring_if.src loop_out,

	output logic result_valid_o,
	output csa_pkg::word_t result_o,
	output csa_pkg::tag_t result_tag_o,
	output csa_pkg::word_t result_seed_o,
	output csa_pkg::count_t result_total_o,
	output csa_pkg::count_t result_start_o
);

	logic last_pass;
	logic matched;
	logic want_emit;
	logic blocked;
	logic emit;
	logic free_slot;

	assign last_pass = (chk_in.left == 1);

	// masked compare of the intermediate word
	assign matched = mask_enable_i && ((chk_in.word & mask_i) == (value_i & mask_i));

	assign want_emit = chk_in.valid && (last_pass || matched);
	assign blocked = want_emit && out_full_i; // output side full so the pass is redone
	assign emit = want_emit && !out_full_i;
	assign free_slot = emit && last_pass;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid_o <= 1'b0;
			loop_out.valid <= 1'b0;
		end else begin
			result_valid_o <= emit;
			loop_out.valid <= chk_in.valid && !free_slot;
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			result_o <= chk_in.word;
			result_tag_o <= chk_in.tag;
			result_seed_o <= chk_in.seed;
			result_total_o <= chk_in.total;
			result_start_o <= chk_in.start;
		end
	end

	// slot goes back round to the entry
	always_ff @(posedge clk) begin
		loop_out.tag <= chk_in.tag;
		loop_out.seed <= chk_in.seed;
		loop_out.total <= chk_in.total;
		loop_out.start <= chk_in.start;
		if (blocked) begin
			// same pass again from the same key
			loop_out.left <= chk_in.left;
			loop_out.word <= key_i;
		end else begin
			loop_out.left <= chk_in.left - 1;
			loop_out.word <= chk_in.word; // feeds the next pass
		end
	end

endmodule

`default_nettype wire

// File: logic/ring_delay.sv
`timescale 1ns/1ps
`default_nettype none

module ring_delay #(
	parameter int DELAY_STAGES = 16,
	parameter int FIFO_LATENCY = 3
) (
	input wire logic clk,
	input wire logic rst_n,

	ring_if.snk dly_in,
	input wire csa_pkg::word_t key_i,
	ring_if.src dly_out,
	output csa_pkg::word_t key_o,
	output logic tap_busy_o
);

	// read pulse goes out a cycle after the tap and the capture FIFO_LATENCY later
	localparam int TAP = DELAY_STAGES - FIFO_LATENCY - 1;

	logic [DELAY_STAGES-1:0] vld_q;
	csa_pkg::tag_t tag_q [DELAY_STAGES];
	csa_pkg::word_t seed_q [DELAY_STAGES];
	csa_pkg::count_t total_q [DELAY_STAGES];
	csa_pkg::count_t start_q [DELAY_STAGES];
	csa_pkg::count_t left_q [DELAY_STAGES];
	csa_pkg::word_t word_q [DELAY_STAGES];
	csa_pkg::word_t key_q [DELAY_STAGES];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[DELAY_STAGES-2:0], dly_in.valid};
		end
	end

	always_ff @(posedge clk) begin
		tag_q[0] <= dly_in.tag;
		seed_q[0] <= dly_in.seed;
		total_q[0] <= dly_in.total;
		start_q[0] <= dly_in.start;
		left_q[0] <= dly_in.left;
		word_q[0] <= dly_in.word;
		key_q[0] <= key_i;
		for (int i = 1; i < DELAY_STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
			seed_q[i] <= seed_q[i-1];
			total_q[i] <= total_q[i-1];
			start_q[i] <= start_q[i-1];
			left_q[i] <= left_q[i-1];
			word_q[i] <= word_q[i-1];
			key_q[i] <= key_q[i-1];
		end
	end

	assign tap_busy_o = vld_q[TAP];

	assign dly_out.valid = vld_q[DELAY_STAGES-1];
	assign dly_out.tag = tag_q[DELAY_STAGES-1];
	assign dly_out.seed = seed_q[DELAY_STAGES-1];
	assign dly_out.total = total_q[DELAY_STAGES-1];
	assign dly_out.start = start_q[DELAY_STAGES-1];
	assign dly_out.left = left_q[DELAY_STAGES-1];
	assign dly_out.word = word_q[DELAY_STAGES-1];
	assign key_o = key_q[DELAY_STAGES-1];

endmodule

`default_nettype wire

// File: logic/keystream_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module keystream_mixer #(
	parameter int CIPHER_STAGES = 4
) (
	input wire logic clk,
	input wire logic rst_n,

	ring_if.snk mix_in,
	ring_if.src mix_out,
	output csa_pkg::word_t key_o // input key of the pass for retries
);

	logic [CIPHER_STAGES-1:0] vld_q;
	csa_pkg::tag_t tag_q [CIPHER_STAGES];
	csa_pkg::word_t seed_q [CIPHER_STAGES];
	csa_pkg::count_t total_q [CIPHER_STAGES];
	csa_pkg::count_t start_q [CIPHER_STAGES];
	csa_pkg::count_t left_q [CIPHER_STAGES];
	csa_pkg::word_t word_q [CIPHER_STAGES];
	csa_pkg::word_t key_q [CIPHER_STAGES];

	// xor with the constant then rotate left a byte
	function automatic csa_pkg::word_t mix_round(input csa_pkg::word_t w);
		csa_pkg::word_t x;
		x = w ^ csa_pkg::MIX_CONST;
		return {x[csa_pkg::WORD_W-9:0], x[csa_pkg::WORD_W-1:csa_pkg::WORD_W-8]};
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= mix_in.valid;
			for (int i = 1; i < CIPHER_STAGES; i++)
				vld_q[i] <= vld_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		tag_q[0] <= mix_in.tag;
		seed_q[0] <= mix_in.seed;
		total_q[0] <= mix_in.total;
		start_q[0] <= mix_in.start;
		left_q[0] <= mix_in.left;
		word_q[0] <= mix_round(mix_in.word);
		key_q[0] <= mix_in.word;
		for (int i = 1; i < CIPHER_STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
			seed_q[i] <= seed_q[i-1];
			total_q[i] <= total_q[i-1];
			start_q[i] <= start_q[i-1];
			left_q[i] <= left_q[i-1];
			word_q[i] <= mix_round(word_q[i-1]); // one round per stage
			key_q[i] <= key_q[i-1];
		end
	end

	assign mix_out.valid = vld_q[CIPHER_STAGES-1];
	assign mix_out.tag = tag_q[CIPHER_STAGES-1];
	assign mix_out.seed = seed_q[CIPHER_STAGES-1];
	assign mix_out.total = total_q[CIPHER_STAGES-1];
	assign mix_out.start = start_q[CIPHER_STAGES-1];
	assign mix_out.left = left_q[CIPHER_STAGES-1];
	assign mix_out.word = word_q[CIPHER_STAGES-1];
	assign key_o = key_q[CIPHER_STAGES-1];

endmodule

`default_nettype wire

// File: logic/ring_entry.sv
`timescale 1ns/1ps
`default_nettype none

module ring_entry #(
	parameter int FIFO_LATENCY = 3
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic fifo_ready_i,
	input wire logic tap_busy_i,
	output logic fifo_ren_o,

	input wire csa_pkg::tag_t job_tag_i,
	input wire csa_pkg::word_t job_seed_i,
	input wire csa_pkg::count_t job_total_i,
	input wire csa_pkg::count_t job_start_i,

	ring_if.snk loop_in,
	ring_if.src ring_out
);

	logic [FIFO_LATENCY-1:0] ren_hist; // own read pulses, oldest at the top
	logic capture;

	csa_pkg::tag_t nxt_tag;
	csa_pkg::word_t nxt_seed;
	csa_pkg::count_t nxt_total;
	csa_pkg::count_t nxt_start;
	csa_pkg::count_t nxt_left;
	csa_pkg::word_t nxt_key;
	logic first_pass;

	// job popped FIFO_LATENCY cycles ago is on the inputs now
	assign capture = ren_hist[FIFO_LATENCY-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fifo_ren_o <= 1'b0;
			ren_hist <= '0;
		end else begin
			// never back to back since ready may lag a pop by a cycle
			fifo_ren_o <= fifo_ready_i && !tap_busy_i && !fifo_ren_o;
			ren_hist <= (ren_hist << 1) | FIFO_LATENCY'(fifo_ren_o);
		end
	end

	// new job into the empty slot or else the slot coming round
	always_comb begin
		if (capture) begin
			nxt_tag = job_tag_i;
			nxt_seed = job_seed_i;
			nxt_total = job_total_i;
			nxt_start = job_start_i;
			nxt_left = job_total_i - job_start_i;
		end else begin
			nxt_tag = loop_in.tag;
			nxt_seed = loop_in.seed;
			nxt_total = loop_in.total;
			nxt_start = loop_in.start;
			nxt_left = loop_in.left;
		end
	end

	assign first_pass = (nxt_left == nxt_total - nxt_start);

	// key for this pass
	assign nxt_key = first_pass ? nxt_seed : loop_in.word;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ring_out.valid <= 1'b0;
		end else begin
			ring_out.valid <= capture || loop_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		ring_out.tag <= nxt_tag;
		ring_out.seed <= nxt_seed;
		ring_out.total <= nxt_total;
		ring_out.start <= nxt_start;
		ring_out.left <= nxt_left;
		ring_out.word <= nxt_key;
	end

endmodule

`default_nettype wire

// File: logic/ring_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ring_if;

	logic valid; // slot holds a job
	csa_pkg::tag_t tag;
	csa_pkg::word_t seed;
	csa_pkg::count_t total;
	csa_pkg::count_t start;
	csa_pkg::count_t left; // passes remaining
	csa_pkg::word_t word;

	modport src (
		output valid,
		output tag,
		output seed,
		output total,
		output start,
		output left,
		output word
	);

	modport snk (
		input valid,
		input tag,
		input seed,
		input total,
		input start,
		input left,
		input word
	);

endinterface

`default_nettype wire

// File: logic/csa_pkg.sv
`default_nettype none

package csa_pkg;

	// cipher word, count and tag widths
	localparam int WORD_W = 64;
	localparam int COUNT_W = 32;
	localparam int TAG_W = 32;

	// seed, key, intermediate word, mask and compare value
	typedef logic [WORD_W-1:0] word_t;

	// total, start and passes left
	typedef logic [COUNT_W-1:0] count_t;

	// block number of a job
	typedef logic [TAG_W-1:0] tag_t;

	// xored in by every mixing round before the rotate
	localparam word_t MIX_CONST = 64'hE613DB6DC11C4524;

endpackage

`default_nettype wire
